// File: source/l2_pkg.sv
package l2_pkg;

    ////////////////////
    // Default geometry
    ////////////////////

    localparam int L2_INDEX_W  = 4;
    localparam int L2_LINE_W   = 512;
    localparam int L2_OFFSET_W = 4;
    localparam int L2_WAYS     = 4;
    localparam int L2_BEAT_W   = 128;

    // Byte select bits below the word offset
    localparam int L2_BYTE_W   = 2;

    ////////////////////
    // Fixed-width types
    ////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;

    // CPU request, a word read or a byte-enabled word write
    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
        be_t   be;
    } cpu_req_t;

    // Write-through word toward memory
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        be_t   be;
    } mem_wr_t;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        REFILL_WRITE,
        RESPOND
    } ctrl_state_t;

endpackage

// File: source/bram_bytewrite.sv
module bram_bytewrite #(
    parameter int DATA_WIDTH = 512,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                    clk,

    input  logic [ADDR_WIDTH-1:0]   waddr,
    input  logic [DATA_WIDTH-1:0]   din,
    input  logic [DATA_WIDTH/8-1:0] we,

    input  logic [ADDR_WIDTH-1:0]   raddr,
    output logic [DATA_WIDTH-1:0]   dout
);

    localparam int DEPTH = 1 << ADDR_WIDTH;
    localparam int BYTES = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// File: source/l2_data_array.sv
module l2_data_array #(
    parameter int addr_width   = l2_pkg::L2_INDEX_W,
    parameter int data_width   = l2_pkg::L2_LINE_W,
    parameter int offset_width = l2_pkg::L2_OFFSET_W,
    parameter int way          = l2_pkg::L2_WAYS
) (
    input  logic                            clk,

    input  logic [addr_width-1:0]           raddr,
    output logic [way-1:0][data_width-1:0]  dout,

    input  logic [addr_width-1:0]           waddr,
    input  logic [data_width-1:0]           line_din,
    input  l2_pkg::word_t                   word_din,
    input  logic [offset_width-1:0]         offset,
    input  l2_pkg::be_t                     byte_en,
    input  logic [way-1:0]                  way_we,
    // Full line replacement when set, single word otherwise
    input  logic                            replace
);

    localparam int BYTES = data_width / 8;

    logic [data_width-1:0] din;
    logic [BYTES-1:0]      word_be;

    ////////////////////
    // Write steering
    ////////////////////

    // Word and its enables moved to the word slot, 4 bytes per slot
    always_comb begin
        word_be = BYTES'(byte_en) << {offset, 2'b00};
        if (replace) begin
            din = line_din;
        end else begin
            din = data_width'(word_din) << {offset, 5'b00000};
        end
    end

    ////////////////////
    // Way RAMs
    ////////////////////

    for (genvar w = 0; w < way; w++) begin : g_way
        logic [BYTES-1:0] we;

        assign we = !way_we[w] ? '0 : (replace ? '1 : word_be);

        bram_bytewrite #(
            .DATA_WIDTH (data_width),
            .ADDR_WIDTH (addr_width)
        ) u_ram (
            .clk   (clk),
            .waddr (waddr),
            .din   (din),
            .we    (we),
            .raddr (raddr),
            .dout  (dout[w])
        );
    end

    // Only one way is ever written per cycle
    a_one_way_we: assert property (@(posedge clk) $onehot0(way_we))
        else $error("l2_data_array: more than one way write enable");

endmodule

// File: source/l2_tag_array.sv
module l2_tag_array #(
    parameter int addr_width   = l2_pkg::L2_INDEX_W,
    parameter int offset_width = l2_pkg::L2_OFFSET_W,
    parameter int way          = l2_pkg::L2_WAYS,
    localparam int tag_width   =
        $bits(l2_pkg::addr_t) - addr_width - offset_width - l2_pkg::L2_BYTE_W
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [addr_width-1:0] index,
    input  logic [tag_width-1:0]  lookup_tag,

    input  logic                  we,
    input  logic [way-1:0]        we_way,
    input  logic [addr_width-1:0] we_index,
    input  logic [tag_width-1:0]  we_tag,

    output logic                  hit,
    output logic [way-1:0]        hit_way,
    output logic [way-1:0]        victim_way
);

    localparam int SETS  = 1 << addr_width;
    localparam int PTR_W = (way > 1) ? $clog2(way) : 1;

    logic [tag_width-1:0] tags [way][SETS];
    logic [tag_width-1:0] tag_q [way];
    logic [way-1:0]       valid [SETS];
    logic [way-1:0]       valid_q;
    logic [PTR_W-1:0]     rr_ptr [SETS];
    logic [PTR_W-1:0]     ptr_q;
    logic [way-1:0]       match;

    // Tag storage, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < way; w++) begin
            if (we && we_way[w]) begin
                tags[w][we_index] <= we_tag;
            end
            tag_q[w] <= tags[w][index];
        end
    end

    // Valid bits and round-robin pointers per set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
            valid_q <= '0;
            ptr_q   <= '0;
        end else begin
            if (we) begin
                valid[we_index]  <= valid[we_index] | we_way;
                rr_ptr[we_index] <= (rr_ptr[we_index] == PTR_W'(way - 1)) ?
                                    '0 : rr_ptr[we_index] + 1'b1;
            end
            valid_q <= valid[index];
            ptr_q   <= rr_ptr[index];
        end
    end

    ////////////////////
    // Compare and victim
    ////////////////////

    always_comb begin
        for (int w = 0; w < way; w++) begin
            match[w] = valid_q[w] && (tag_q[w] == lookup_tag);
        end
    end

    assign hit     = |match;
    assign hit_way = match;

    // Lowest invalid way wins over the pointer
    always_comb begin
        victim_way        = '0;
        victim_way[ptr_q] = 1'b1;
        for (int w = way - 1; w >= 0; w--) begin
            if (!valid_q[w]) begin
                victim_way    = '0;
                victim_way[w] = 1'b1;
            end
        end
    end

    // Refill only on a miss, so a tag never sits in two ways of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) hit |-> $onehot(hit_way))
        else $error("l2_tag_array: tag matches in more than one way");

endmodule

// File: source/l2_refill_counter.sv
module l2_refill_counter #(
    parameter int data_width = l2_pkg::L2_LINE_W,
    parameter int beat_width = l2_pkg::L2_BEAT_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  beat_valid,
    input  logic [beat_width-1:0] beat,
    output logic [data_width-1:0] line,
    output logic                  done
);

    localparam int BEATS = data_width / beat_width;
    localparam int CNT_W = $clog2(BEATS);

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic             last;

    assign last = (cnt == CNT_W'(BEATS - 1));
    assign done = active && beat_valid && last;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active && beat_valid) begin
            cnt <= cnt + 1'b1;
            if (last) begin
                active <= 1'b0;
            end
        end
    end

    // Lowest slice arrives first
    always_ff @(posedge clk) begin
        if (active && beat_valid) begin
            line[cnt*beat_width +: beat_width] <= beat;
        end
    end

    a_beat_when_active: assert property (@(posedge clk) disable iff (rst) beat_valid |-> active)
        else $error("l2_refill_counter: memory beat with no refill outstanding");

endmodule

// File: source/l2_ctrl.sv
module l2_ctrl #(
    parameter int addr_width   = l2_pkg::L2_INDEX_W,
    parameter int offset_width = l2_pkg::L2_OFFSET_W,
    parameter int way          = l2_pkg::L2_WAYS
) (
    input  logic                  clk,
    input  logic                  rst,

    // CPU side
    input  logic                  req,
    input  l2_pkg::cpu_req_t      req_data,
    output logic                  idle,
    output logic                  rvalid,
    output l2_pkg::word_t         rdata,

    // Tag array results
    input  logic                  hit,
    input  logic [way-1:0]        hit_way,
    input  logic [way-1:0]        victim_way,

    input  logic                  refill_done,
    input  l2_pkg::word_t         line_dout_word,

    // Array control
    output logic [addr_width-1:0] rd_index,
    output l2_pkg::addr_t         lookup_addr,
    output logic                  tag_we,
    output logic [way-1:0]        tag_way,
    output logic [way-1:0]        data_way_we,
    output logic                  data_replace,
    output logic                  refill_start,

    // Memory side
    output logic                  mem_rd,
    output l2_pkg::addr_t         mem_rd_addr,
    output logic                  mem_wr,
    output l2_pkg::mem_wr_t       mem_wr_data
);

    import l2_pkg::*;

    localparam int IDX_LO = L2_BYTE_W + offset_width;

    ctrl_state_t    state;
    cpu_req_t       req_q;
    logic [way-1:0] fill_way;
    // Extra RESPOND cycle after a refill so the new line is re-read
    logic           resp_wait;

    assign idle        = (state == IDLE);
    assign lookup_addr = req_q.addr;

    // RAMs follow the incoming request while idle, the held one otherwise
    assign rd_index = idle ? req_data.addr[IDX_LO +: addr_width]
                           : req_q.addr[IDX_LO +: addr_width];

    ////////////////////
    // Memory requests
    ////////////////////

    assign mem_rd       = (state == REFILL_REQ);
    assign refill_start = mem_rd;
    assign mem_rd_addr  = {req_q.addr[$bits(addr_t)-1:IDX_LO], {IDX_LO{1'b0}}};

    assign mem_wr      = (state == LOOKUP) && req_q.write;
    assign mem_wr_data = '{addr: req_q.addr, wdata: req_q.wdata, be: req_q.be};

    ////////////////////
    // Array writes
    ////////////////////

    assign tag_we       = (state == REFILL_WRITE);
    assign tag_way      = fill_way;
    assign data_replace = tag_we;

    always_comb begin
        data_way_we = '0;
        if (state == LOOKUP && req_q.write && hit) begin
            data_way_we = hit_way;
        end else if (state == REFILL_WRITE) begin
            data_way_we = fill_way;
        end
    end

    // Sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            rvalid    <= 1'b0;
            resp_wait <= 1'b0;
        end else begin
            rvalid <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    // Write-through, no allocate on a miss
                    if (req_q.write) begin
                        state <= IDLE;
                    end else if (hit) begin
                        resp_wait <= 1'b0;
                        state     <= RESPOND;
                    end else begin
                        state <= REFILL_REQ;
                    end
                end
                REFILL_REQ: state <= REFILL_WAIT;
                REFILL_WAIT: begin
                    if (refill_done) begin
                        state <= REFILL_WRITE;
                    end
                end
                REFILL_WRITE: begin
                    resp_wait <= 1'b1;
                    state     <= RESPOND;
                end
                RESPOND: begin
                    if (resp_wait) begin
                        resp_wait <= 1'b0;
                    end else begin
                        rvalid <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && req) begin
            req_q <= req_data;
        end
        if (state == LOOKUP && !hit) begin
            fill_way <= victim_way;
        end
        if (state == RESPOND) begin
            rdata <= line_dout_word;
        end
    end

    a_req_when_idle: assert property (@(posedge clk) disable iff (rst) req |-> idle)
        else $error("l2_ctrl: request strobe while the cache is busy");

    // The refilled line must hit on its re-read
    a_respond_hits: assert property (@(posedge clk) disable iff (rst)
        (state == RESPOND && !resp_wait) |-> hit)
        else $error("l2_ctrl: read response without a tag hit");

endmodule

// File: source/l2_cache.sv
module l2_cache #(
    parameter int addr_width   = l2_pkg::L2_INDEX_W,
    parameter int data_width   = l2_pkg::L2_LINE_W,
    parameter int offset_width = l2_pkg::L2_OFFSET_W,
    parameter int way          = l2_pkg::L2_WAYS,
    parameter int beat_width   = l2_pkg::L2_BEAT_W
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req,
    input  l2_pkg::cpu_req_t      req_data,
    output logic                  idle,
    output logic                  rvalid,
    output l2_pkg::word_t         rdata,

    output logic                  mem_rd,
    output l2_pkg::addr_t         mem_rd_addr,
    input  logic                  mem_beat_valid,
    input  logic [beat_width-1:0] mem_beat,
    output logic                  mem_wr,
    output l2_pkg::mem_wr_t       mem_wr_data
);

    import l2_pkg::*;

    localparam int IDX_LO = L2_BYTE_W + offset_width;
    localparam int TAG_LO = IDX_LO + addr_width;

    logic [addr_width-1:0]          rd_index;
    addr_t                          lookup_addr;
    logic [$bits(addr_t)-TAG_LO-1:0] lookup_tag;
    logic [addr_width-1:0]          lookup_index;
    logic [offset_width-1:0]        lookup_offset;
    logic                           tag_we;
    logic [way-1:0]                 tag_way;
    logic [way-1:0]                 data_way_we;
    logic                           data_replace;
    logic                           refill_start;
    logic                           refill_done;
    logic [data_width-1:0]          refill_line;
    logic                           hit;
    logic [way-1:0]                 hit_way;
    logic [way-1:0]                 victim_way;
    logic [way-1:0][data_width-1:0] line_dout;
    logic [data_width-1:0]          hit_line;
    word_t                          line_dout_word;

    assign lookup_tag    = lookup_addr[$bits(addr_t)-1:TAG_LO];
    assign lookup_index  = lookup_addr[IDX_LO +: addr_width];
    assign lookup_offset = lookup_addr[L2_BYTE_W +: offset_width];

    ////////////////////
    // Read word mux
    ////////////////////

    // hit_way is one-hot, so an OR of the masked ways picks the line
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < way; w++) begin
            if (hit_way[w]) begin
                hit_line = hit_line | line_dout[w];
            end
        end
    end

    assign line_dout_word = hit_line[lookup_offset*$bits(word_t) +: $bits(word_t)];

    l2_ctrl #(
        .addr_width   (addr_width),
        .offset_width (offset_width),
        .way          (way)
    ) u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .req_data       (req_data),
        .idle           (idle),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .refill_done    (refill_done),
        .line_dout_word (line_dout_word),
        .rd_index       (rd_index),
        .lookup_addr    (lookup_addr),
        .tag_we         (tag_we),
        .tag_way        (tag_way),
        .data_way_we    (data_way_we),
        .data_replace   (data_replace),
        .refill_start   (refill_start),
        .mem_rd         (mem_rd),
        .mem_rd_addr    (mem_rd_addr),
        .mem_wr         (mem_wr),
        .mem_wr_data    (mem_wr_data)
    );

    l2_tag_array #(
        .addr_width   (addr_width),
        .offset_width (offset_width),
        .way          (way)
    ) u_tags (
        .clk        (clk),
        .rst        (rst),
        .index      (rd_index),
        .lookup_tag (lookup_tag),
        .we         (tag_we),
        .we_way     (tag_way),
        .we_index   (lookup_index),
        .we_tag     (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    l2_data_array #(
        .addr_width   (addr_width),
        .data_width   (data_width),
        .offset_width (offset_width),
        .way          (way)
    ) u_data (
        .clk      (clk),
        .raddr    (rd_index),
        .dout     (line_dout),
        .waddr    (lookup_index),
        .line_din (refill_line),
        .word_din (mem_wr_data.wdata),
        .offset   (lookup_offset),
        .byte_en  (mem_wr_data.be),
        .way_we   (data_way_we),
        .replace  (data_replace)
    );

    l2_refill_counter #(
        .data_width (data_width),
        .beat_width (beat_width)
    ) u_refill (
        .clk        (clk),
        .rst        (rst),
        .start      (refill_start),
        .beat_valid (mem_beat_valid),
        .beat       (mem_beat),
        .line       (refill_line),
        .done       (refill_done)
    );

endmodule

// File: testbench/l2_mem_model.sv
module l2_mem_model #(
    parameter int words_log2 = 12,
    parameter int line_width = l2_pkg::L2_LINE_W,
    parameter int beat_width = l2_pkg::L2_BEAT_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd,
    input  l2_pkg::addr_t         rd_addr,
    output logic                  beat_valid,
    output logic [beat_width-1:0] beat,
    input  logic                  wr,
    input  l2_pkg::mem_wr_t       wr_data
);

    timeunit 1ns;
    timeprecision 100ps;

    import l2_pkg::*;

    localparam int DEPTH      = 1 << words_log2;
    localparam int WORD_W     = $bits(word_t);
    localparam int BEAT_WORDS = beat_width / WORD_W;
    localparam int BEATS      = line_width / beat_width;

    word_t words [DEPTH];

    // Power-up contents, then byte-enabled word writes
    initial begin
        logic [words_log2-1:0] widx;
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h6b1d_0000;
        end
        forever begin
            @(negedge clk);
            if (!rst && wr) begin
                widx = wr_data.addr[2 +: words_log2];
                for (int b = 0; b < WORD_W / 8; b++) begin
                    if (wr_data.be[b]) begin
                        words[widx][b*8 +: 8] = wr_data.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    ////////////////////
    // Line reads
    ////////////////////

    // Beats go out lowest word first, with an optional idle cycle between them
    initial begin
        logic [words_log2-1:0] ridx;
        int unsigned           delay;
        int unsigned           gap;
        beat_valid = 1'b0;
        beat       = '0;
        forever begin
            @(negedge clk);
            if (!rst && rd) begin
                ridx  = rd_addr[2 +: words_log2];
                delay = $urandom_range(6, 2);
                repeat (delay) @(negedge clk);
                for (int b = 0; b < BEATS; b++) begin
                    for (int k = 0; k < BEAT_WORDS; k++) begin
                        beat[k*WORD_W +: WORD_W] = words[ridx + words_log2'(b*BEAT_WORDS + k)];
                    end
                    beat_valid = 1'b1;
                    @(negedge clk);
                    beat_valid = 1'b0;
                    gap = $urandom_range(1, 0);
                    repeat (gap) @(negedge clk);
                end
            end
        end
    end

endmodule

// File: testbench/l2_cache_tb.sv
module l2_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import l2_pkg::*;

    localparam int MEM_WORDS_LOG2 = 12;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int RANDOM_OPS     = 300;

    logic                 clk;
    logic                 rst;
    logic                 req;
    cpu_req_t             req_data;
    logic                 idle;
    logic                 rvalid;
    word_t                rdata;
    logic                 mem_rd;
    addr_t                mem_rd_addr;
    logic                 mem_beat_valid;
    logic [L2_BEAT_W-1:0] mem_beat;
    logic                 mem_wr;
    mem_wr_t              mem_wr_data;

    // Reference state
    word_t   shadow [1 << MEM_WORDS_LOG2];
    word_t   exp_rdata [$];
    mem_wr_t exp_wr [$];
    addr_t   exp_rd_addr;
    string   test_name;
    int      cycle = 0;
    int      accept_cycle;
    int      last_latency;
    int      rd_count = 0;
    int      wr_count = 0;

    l2_cache #(
        .addr_width   (L2_INDEX_W),
        .data_width   (L2_LINE_W),
        .offset_width (L2_OFFSET_W),
        .way          (L2_WAYS),
        .beat_width   (L2_BEAT_W)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .req_data       (req_data),
        .idle           (idle),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .mem_rd         (mem_rd),
        .mem_rd_addr    (mem_rd_addr),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat),
        .mem_wr         (mem_wr),
        .mem_wr_data    (mem_wr_data)
    );

    l2_mem_model #(
        .words_log2 (MEM_WORDS_LOG2),
        .line_width (L2_LINE_W),
        .beat_width (L2_BEAT_W)
    ) mem_i (
        .clk        (clk),
        .rst        (rst),
        .rd         (mem_rd),
        .rd_addr    (mem_rd_addr),
        .beat_valid (mem_beat_valid),
        .beat       (mem_beat),
        .wr         (mem_wr),
        .wr_data    (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic end_failed();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string name, input word_t exp, input word_t act);
        $display("ERR %s: expected %h, actual %h", name, exp, act);
        end_failed();
    endtask

    task automatic fault(input string what);
        $display("%s", what);
        end_failed();
    endtask

    task automatic check_equal(input string name, input word_t exp, input word_t act);
        assert (act == exp) else mismatch(name, exp, act);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Same power-up rule as the memory model
    function automatic word_t power_up_word(int unsigned idx);
        return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h6b1d_0000;
    endfunction

    function automatic logic [MEM_WORDS_LOG2-1:0] word_index(addr_t addr);
        return addr[2 +: MEM_WORDS_LOG2];
    endfunction

    function automatic word_t expected_word(addr_t addr);
        return shadow[word_index(addr)];
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, be_t be);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Read words and write-through traffic checked on the falling edge
    always @(negedge clk) begin
        word_t   exp_word;
        mem_wr_t exp_w;
        if (!rst) begin
            if (rvalid) begin
                assert (exp_rdata.size() != 0)
                    else fault("rvalid pulsed with no read outstanding");
                exp_word = exp_rdata.pop_front();
                check_equal(test_name, exp_word, rdata);
            end
            if (mem_wr) begin
                assert (exp_wr.size() != 0)
                    else fault("mem_wr pulsed with no write issued");
                exp_w = exp_wr.pop_front();
                check_equal({test_name, " mem_wr addr"}, exp_w.addr, mem_wr_data.addr);
                check_equal({test_name, " mem_wr data"}, exp_w.wdata, mem_wr_data.wdata);
                check_equal({test_name, " mem_wr be"}, word_t'(exp_w.be),
                            word_t'(mem_wr_data.be));
                wr_count = wr_count + 1;
            end
            if (mem_rd) begin
                check_equal({test_name, " mem_rd addr"}, exp_rd_addr, mem_rd_addr);
                rd_count = rd_count + 1;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!idle) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT_CYCLES) else fault("cache never returned to idle");
        end
    endtask

    task automatic send_request(input logic write, input addr_t addr, input word_t wdata,
                                input be_t be);
        mem_wr_t wr_item;
        wait_idle();
        req          = 1'b1;
        req_data     = '{addr: addr, write: write, wdata: wdata, be: be};
        accept_cycle = cycle + 1;
        if (write) begin
            wr_item.addr  = addr;
            wr_item.wdata = wdata;
            wr_item.be    = be;
            exp_wr.push_back(wr_item);
            shadow[word_index(addr)] = merge_bytes(expected_word(addr), wdata, be);
        end else begin
            // A refill asks for the whole 64-byte line
            exp_rd_addr = addr & ~addr_t'(L2_LINE_W / 8 - 1);
            exp_rdata.push_back(expected_word(addr));
        end
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic read_word(input addr_t addr);
        int waited;
        waited = 0;
        send_request(1'b0, addr, '0, '0);
        do begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT_CYCLES) else fault("read response never arrived");
        end while (!rvalid);
        last_latency = cycle - accept_cycle;
    endtask

    task automatic write_word(input addr_t addr, input word_t wdata, input be_t be);
        send_request(1'b1, addr, wdata, be);
        wait_idle();
    endtask

    initial begin
        int    rd0;
        int    wr0;
        addr_t addr;
        void'($urandom(32'h3431_8d5f));
        rst         = 1'b1;
        req         = 1'b0;
        req_data    = '0;
        exp_rd_addr = '0;
        test_name   = "reset";
        for (int i = 0; i < (1 << MEM_WORDS_LOG2); i++) begin
            shadow[i] = power_up_word(i);
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        assert (idle && !rvalid && !mem_rd && !mem_wr)
            else fault("cache outputs are not in their reset state");

        test_name = "cold_miss";
        rd0 = rd_count;
        read_word(32'h0000_0048);
        check_equal("cold_miss mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));
        read_word(32'h0000_0048);
        check_equal("cold_miss re-read mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));

        test_name = "hit_latency";
        rd0 = rd_count;
        read_word(32'h0000_0044);
        check_equal("hit_latency cycles", 32'd2, word_t'(last_latency));
        check_equal("hit_latency mem_rd count", word_t'(rd0), word_t'(rd_count));

        test_name = "partial_write";
        wr0 = wr_count;
        write_word(32'h0000_0048, 32'hdead_beef, 4'b0101);
        check_equal("partial_write mem_wr count", word_t'(wr0 + 1), word_t'(wr_count));
        read_word(32'h0000_0048);
        check_equal("partial_write mem_rd count", word_t'(rd0), word_t'(rd_count));

        test_name = "write_miss";
        rd0 = rd_count;
        wr0 = wr_count;
        write_word(32'h0000_0884, 32'h1234_5678, 4'b1111);
        check_equal("write_miss mem_wr count", word_t'(wr0 + 1), word_t'(wr_count));
        check_equal("write_miss mem_rd count", word_t'(rd0), word_t'(rd_count));
        read_word(32'h0000_0884);
        check_equal("write_miss read mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));

        // Five tags in set 9, the fifth fill evicts way 0
        test_name = "eviction";
        for (int k = 0; k < 5; k++) begin
            rd0 = rd_count;
            read_word(32'h0000_0244 + addr_t'(k) * 32'h400);
            check_equal("eviction fill mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));
        end
        rd0 = rd_count;
        read_word(32'h0000_0244);
        check_equal("eviction re-read mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));
        read_word(32'h0000_1244);
        check_equal("eviction kept line mem_rd count", word_t'(rd0 + 1), word_t'(rd_count));

        // Eight tags over two sets, so hits, misses and evictions mix
        test_name = "random";
        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = addr_t'(($urandom_range(7, 0) << 10) | ($urandom_range(1, 0) << 6) |
                           ($urandom_range(15, 0) << 2));
            if ($urandom_range(1, 0) == 1) begin
                write_word(addr, $urandom(), be_t'($urandom_range(15, 0)));
            end else begin
                read_word(addr);
            end
        end

        wait_idle();
        @(negedge clk);
        assert (exp_rdata.size() == 0 && exp_wr.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fault("responses still outstanding at the end of the run");
        end
    end

endmodule

// File: l2_cache.f
source/l2_pkg.sv
source/bram_bytewrite.sv
source/l2_data_array.sv
source/l2_tag_array.sv
source/l2_refill_counter.sv
source/l2_ctrl.sv
source/l2_cache.sv
testbench/l2_mem_model.sv
testbench/l2_cache_tb.sv

// File: Makefile
# Verilator build for the L2 cache slice

VERILATOR  ?= verilator
TOP        ?= l2_cache_tb
RTL_TOP    ?= l2_cache
FILELIST   ?= l2_cache.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass or fail is taken from the simulation output only
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
